/* fpu_slice_pkg.sv */
// ----------------------------
// Formats share one encoding across the slice, FP8 here is 1-5-2
// ----------------------------
package fpu_slice_pkg;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2
  } fp_format_e;

  localparam int unsigned NUM_FORMATS = 3;

  typedef enum logic {
    MINMAX = 1'b0,
    SGNJ   = 1'b1
  } operation_e;

  // IEEE exception flags, only nv is raised by this group
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Travels with each item through the lanes
  typedef struct packed {
    logic       vectorial;
    fp_format_e fmt;
  } aux_t;

  // ----------------------------
  // Format geometry
  // ----------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP32:    return 32;
      FP16:    return 16;
      default: return 8;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    return (fmt == FP32) ? 8 : 5;
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    case (fmt)
      FP32:    return 23;
      FP16:    return 10;
      default: return 2;
    endcase
  endfunction

  // Widest format whose element at this lane index still fits
  function automatic int unsigned lane_width(int unsigned width, int unsigned lane);
    int unsigned res;
    res = 0;
    for (int f = NUM_FORMATS - 1; f >= 0; f--) begin
      if (fp_width(fp_format_e'(f)) * (lane + 1) <= width) res = fp_width(fp_format_e'(f));
    end
    return res;
  endfunction

  function automatic int unsigned num_lanes(int unsigned width);
    int unsigned min_w;
    min_w = fp_width(FP32);
    for (int f = 0; f < NUM_FORMATS; f++) begin
      if (fp_width(fp_format_e'(f)) < min_w) min_w = fp_width(fp_format_e'(f));
    end
    return width / min_w;
  endfunction

  function automatic int unsigned lanes_for_format(int unsigned width, fp_format_e fmt);
    return width / fp_width(fmt);
  endfunction

endpackage

/* lane_if.sv */
// ----------------------------
// All lanes of an array share one LaneWidth, the widest lane's
// ----------------------------
`timescale 1ns/10ps

// Operand side link, slicer to one lane
interface lane_in_if import fpu_slice_pkg::*; #(
  parameter int unsigned LaneWidth = 32,
  parameter type         TagType   = logic
);
  logic                 valid;
  logic                 ready;
  logic [LaneWidth-1:0] operand_a;
  logic [LaneWidth-1:0] operand_b;
  operation_e           op;
  logic                 op_mod;
  fp_format_e           fmt;
  TagType               tag;
  aux_t                 aux;

  modport slicer (output valid, operand_a, operand_b, op, op_mod, fmt, tag, aux,
                  input  ready);
  modport lane   (input  valid, operand_a, operand_b, op, op_mod, fmt, tag, aux,
                  output ready);
endinterface

// Result side link, one lane to the packer
interface lane_out_if import fpu_slice_pkg::*; #(
  parameter int unsigned LaneWidth = 32,
  parameter type         TagType   = logic
);
  logic                 valid;
  logic                 ready;
  logic [LaneWidth-1:0] result;
  status_t              status;
  TagType               tag;
  aux_t                 aux;
  logic                 busy;   // Any stage of the lane holds an item

  modport lane   (output valid, result, status, tag, aux, busy,
                  input  ready);
  modport packer (input  valid, result, status, tag, aux, busy,
                  output ready);
endinterface

/* operand_slicer.sv */
// ----------------------------
// Operands are used as given, no NaN-box check on the inputs
// ----------------------------
`timescale 1ns/10ps

module operand_slicer import fpu_slice_pkg::*; #(
  parameter int unsigned Width         = 32,
  parameter logic        EnableVectors = 1'b1,
  parameter int unsigned NumLanes      = 4,
  parameter type         TagType       = logic
) (
  input  logic [1:0][Width-1:0] operands_i,
  input  operation_e            op_i,
  input  logic                  op_mod_i,
  input  fp_format_e            fmt_i,
  input  logic                  vectorial_op_i,
  input  TagType                tag_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  lane_in_if.slicer             lanes_o [NumLanes]
);

  localparam int unsigned MAX_LANE_WIDTH = lane_width(Width, 0);

  logic vectorial_op;
  aux_t aux;

  assign vectorial_op = vectorial_op_i & EnableVectors;
  assign aux          = '{vectorial: vectorial_op, fmt: fmt_i};
  assign in_ready_o   = lanes_o[0].ready;   // Lane 0 paces the whole slice

  for (genvar k = 0; k < NumLanes; k++) begin : gen_lanes
    logic             active;
    logic [Width-1:0] a_shift;
    logic [Width-1:0] b_shift;

    assign active = (k == 0) || (vectorial_op && (k < lanes_for_format(Width, fmt_i)));

    // Upper lanes only take an item in the cycle lane 0 takes it,
    // so all copies of one vector stay in the same order
    if (k == 0) begin : gen_lead
      assign lanes_o[k].valid = in_valid_i;
    end else begin : gen_follow
      assign lanes_o[k].valid = in_valid_i & active & lanes_o[0].ready;
    end

    // Element k sits at k times the element width
    assign a_shift = operands_i[0] >> (k * fp_width(fmt_i));
    assign b_shift = operands_i[1] >> (k * fp_width(fmt_i));

    assign lanes_o[k].operand_a = a_shift[MAX_LANE_WIDTH-1:0];
    assign lanes_o[k].operand_b = b_shift[MAX_LANE_WIDTH-1:0];
    assign lanes_o[k].op        = op_i;
    assign lanes_o[k].op_mod    = op_mod_i;
    assign lanes_o[k].fmt       = fmt_i;
    assign lanes_o[k].tag       = tag_i;
    assign lanes_o[k].aux       = aux;
  end

  // Caller must not ask for vectors on a scalar-only build
  always_comb begin : vec_check
    if (in_valid_i) begin
      assert (EnableVectors || !vectorial_op_i)
        else $error("vectorial op requested with vectors disabled");
    end
  end

endmodule

/* noncomp_lane.sv */
// ----------------------------
// Formats wider than LaneWidth are not computed, the lane is inactive for them
// ----------------------------
`timescale 1ns/10ps

module noncomp_lane import fpu_slice_pkg::*; #(
  parameter int unsigned LaneWidth   = 32,
  parameter int unsigned NumPipeRegs = 2,
  parameter type         TagType     = logic
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      flush_i,
  lane_in_if.lane   in_p,
  lane_out_if.lane  out_p
);

  logic [NUM_FORMATS-1:0][LaneWidth-1:0] fmt_res;
  logic [NUM_FORMATS-1:0]                fmt_nv;
  logic [LaneWidth-1:0]                  op_res;
  status_t                               op_status;

  // ----------------------------
  // Per-format datapath
  // ----------------------------
  for (genvar f = 0; f < NUM_FORMATS; f++) begin : gen_fmt
    localparam int unsigned FW = fp_width(fp_format_e'(f));
    localparam int unsigned EB = exp_bits(fp_format_e'(f));
    localparam int unsigned MB = man_bits(fp_format_e'(f));

    if (FW <= LaneWidth) begin : gen_fit
      logic [FW-1:0]        a, b, minmax, sgnj;
      logic [LaneWidth-1:0] res;
      logic                 a_nan, b_nan, a_lt_b;

      assign a     = in_p.operand_a[FW-1:0];
      assign b     = in_p.operand_b[FW-1:0];
      assign a_nan = (&a[FW-2 -: EB]) && (|a[MB-1:0]);
      assign b_nan = (&b[FW-2 -: EB]) && (|b[MB-1:0]);

      always_comb begin : minmax_sel
        // Sign-magnitude order, -0 sorts below +0
        if (a[FW-1] != b[FW-1]) a_lt_b = a[FW-1];
        else if (a[FW-1])       a_lt_b = a[FW-2:0] > b[FW-2:0];
        else                    a_lt_b = a[FW-2:0] < b[FW-2:0];

        if (a_nan && b_nan) minmax = {1'b0, {EB{1'b1}}, 1'b1, {(MB-1){1'b0}}};
        else if (a_nan)     minmax = b;
        else if (b_nan)     minmax = a;
        else                minmax = (a_lt_b ^ in_p.op_mod) ? a : b;   // op_mod 1 is max
      end

      assign sgnj = {b[FW-1] ^ in_p.op_mod, a[FW-2:0]};

      always_comb begin : box
        res         = '1;   // NaN-box above the element
        res[FW-1:0] = (in_p.op == SGNJ) ? sgnj : minmax;
      end

      assign fmt_res[f] = res;
      // Signaling NaN has the quiet bit clear
      assign fmt_nv[f]  = (in_p.op == MINMAX) &&
                          ((a_nan && !a[MB-1]) || (b_nan && !b[MB-1]));
    end else begin : gen_nofit
      assign fmt_res[f] = '1;
      assign fmt_nv[f]  = 1'b0;
    end
  end

  always_comb begin : fmt_sel
    op_res    = '1;
    op_status = '0;
    for (int f = 0; f < NUM_FORMATS; f++) begin
      if (in_p.fmt == fp_format_e'(f)) begin
        op_res       = fmt_res[f];
        op_status.nv = fmt_nv[f];
      end
    end
  end

  // ----------------------------
  // Pipeline, index i is after i stages
  // ----------------------------
  logic [LaneWidth-1:0] pipe_res    [0:NumPipeRegs];
  status_t              pipe_status [0:NumPipeRegs];
  TagType               pipe_tag    [0:NumPipeRegs];
  aux_t                 pipe_aux    [0:NumPipeRegs];
  logic [0:NumPipeRegs] pipe_valid;
  logic [0:NumPipeRegs] pipe_ready;

  assign pipe_res[0]    = op_res;
  assign pipe_status[0] = op_status;
  assign pipe_tag[0]    = in_p.tag;
  assign pipe_aux[0]    = in_p.aux;
  assign pipe_valid[0]  = in_p.valid;
  assign in_p.ready     = pipe_ready[0];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe
    // Advance when downstream takes it or holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)          pipe_valid[i+1] <= 1'b0;
      else if (flush_i)       pipe_valid[i+1] <= 1'b0;
      else if (pipe_ready[i]) pipe_valid[i+1] <= pipe_valid[i];
    end

    always_ff @(posedge clk_i) begin
      if (pipe_ready[i] && pipe_valid[i]) begin
        pipe_res[i+1]    <= pipe_res[i];
        pipe_status[i+1] <= pipe_status[i];
        pipe_tag[i+1]    <= pipe_tag[i];
        pipe_aux[i+1]    <= pipe_aux[i];
      end
    end
  end

  assign pipe_ready[NumPipeRegs] = out_p.ready;

  always_comb begin : out_box
    out_p.result                = '1;
    out_p.result[LaneWidth-1:0] = pipe_res[NumPipeRegs];
  end

  assign out_p.valid  = pipe_valid[NumPipeRegs];
  assign out_p.status = pipe_status[NumPipeRegs];
  assign out_p.tag    = pipe_tag[NumPipeRegs];
  assign out_p.aux    = pipe_aux[NumPipeRegs];
  assign out_p.busy   = |pipe_valid;

  if (NumPipeRegs > 0) begin : gen_stall_check
    stable_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (pipe_valid[NumPipeRegs] && !out_p.ready && !flush_i) |=>
        (pipe_valid[NumPipeRegs] && $stable(pipe_res[NumPipeRegs]) &&
         $stable(pipe_tag[NumPipeRegs])))
      else $error("lane output changed while stalled");
  end

endmodule

/* result_packer.sv */
// ----------------------------
// Format and vector flag are taken from lane 0 only
// ----------------------------
`timescale 1ns/10ps

module result_packer import fpu_slice_pkg::*; #(
  parameter int unsigned Width    = 32,
  parameter int unsigned NumLanes = 4,
  parameter type         TagType  = logic
) (
  lane_out_if.packer    lanes_i [NumLanes],
  input  logic          out_ready_i,
  output logic          out_valid_o,
  output logic [Width-1:0] result_o,
  output status_t       status_o,
  output TagType        tag_o,
  output logic          busy_o
);

  localparam int unsigned MAX_LANE_WIDTH = lane_width(Width, 0);

  aux_t                              res_aux;
  logic [NumLanes-1:0]               lane_active;
  logic [NumLanes-1:0]               lane_valid;
  logic [NumLanes-1:0]               lane_busy;
  status_t [NumLanes-1:0]            lane_status;
  logic [MAX_LANE_WIDTH-1:0]         lane_result [NumLanes];
  logic [NUM_FORMATS-1:0][Width-1:0] fmt_result;

  assign res_aux = lanes_i[0].aux;

  for (genvar k = 0; k < NumLanes; k++) begin : gen_lanes
    assign lane_active[k] = (k == 0) ||
                            (res_aux.vectorial && (k < lanes_for_format(Width, res_aux.fmt)));
    assign lanes_i[k].ready = out_ready_i & lane_active[k];   // Idle lanes are never drained
    assign lane_valid[k]    = lanes_i[k].valid;
    assign lane_busy[k]     = lanes_i[k].busy;
    assign lane_result[k]   = lanes_i[k].result;
    assign lane_status[k]   = (lane_valid[k] && lane_active[k]) ? lanes_i[k].status : '0;
  end

  // ----------------------------
  // Packing per format
  // ----------------------------
  for (genvar f = 0; f < NUM_FORMATS; f++) begin : gen_fmt
    localparam int unsigned FW        = fp_width(fp_format_e'(f));
    localparam int unsigned NUM_ELEMS = Width / FW;

    for (genvar e = 0; e < NUM_ELEMS; e++) begin : gen_elem
      assign fmt_result[f][e*FW +: FW] = lane_active[e] ? lane_result[e][FW-1:0] : '1;
    end
    if (NUM_ELEMS * FW < Width) begin : gen_fill
      assign fmt_result[f][Width-1:NUM_ELEMS*FW] = '1;
    end
  end

  always_comb begin : fmt_sel
    result_o = '1;
    for (int f = 0; f < NUM_FORMATS; f++) begin
      if (res_aux.fmt == fp_format_e'(f)) result_o = fmt_result[f];
    end
  end

  always_comb begin : status_merge
    status_o = '0;
    for (int k = 0; k < NumLanes; k++) status_o |= lane_status[k];
  end

  assign out_valid_o = lane_valid[0];
  assign tag_o       = lanes_i[0].tag;
  assign busy_o      = |lane_busy;

  // Copies of a vector must reach the output in the same cycle
  always_comb begin : lockstep_check
    if (lane_valid[0]) begin
      assert ((lane_valid & lane_active) == lane_active)
        else $error("active lane not valid with lane 0");
    end
  end

endmodule

/* fpu_noncomp_slice.sv */
// ----------------------------
// MINMAX and SGNJ only, no rounding mode and no SGNJX
// ----------------------------
`timescale 1ns/10ps

module fpu_noncomp_slice import fpu_slice_pkg::*; #(
  parameter int unsigned Width         = 32,
  parameter int unsigned NumPipeRegs   = 2,
  parameter logic        EnableVectors = 1'b1,
  parameter type         TagType       = logic [3:0]
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [1:0][Width-1:0] operands_i,
  input  operation_e            op_i,
  input  logic                  op_mod_i,
  input  fp_format_e            fmt_i,
  input  logic                  vectorial_op_i,
  input  TagType                tag_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  output logic [Width-1:0]      result_o,
  output status_t               status_o,
  output TagType                tag_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  localparam int unsigned NUM_LANES      = num_lanes(Width);
  localparam int unsigned MAX_LANE_WIDTH = lane_width(Width, 0);

  lane_in_if  #(.LaneWidth(MAX_LANE_WIDTH), .TagType(TagType)) lane_in  [NUM_LANES] ();
  lane_out_if #(.LaneWidth(MAX_LANE_WIDTH), .TagType(TagType)) lane_out [NUM_LANES] ();

  operand_slicer #(
    .Width         (Width),
    .EnableVectors (EnableVectors),
    .NumLanes      (NUM_LANES),
    .TagType       (TagType)
  ) i_slicer (
    .operands_i     (operands_i),
    .op_i           (op_i),
    .op_mod_i       (op_mod_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .tag_i          (tag_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .lanes_o        (lane_in)
  );

  // Lane k is sized for the widest element it can ever hold
  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lanes
    noncomp_lane #(
      .LaneWidth   (lane_width(Width, k)),
      .NumPipeRegs (NumPipeRegs),
      .TagType     (TagType)
    ) i_lane (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .flush_i  (flush_i),
      .in_p     (lane_in[k]),
      .out_p    (lane_out[k])
    );
  end

  result_packer #(
    .Width    (Width),
    .NumLanes (NUM_LANES),
    .TagType  (TagType)
  ) i_packer (
    .lanes_i     (lane_out),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .busy_o      (busy_o)
  );

endmodule

/* tb_fpu_noncomp_slice.sv */
// ------------------------------
// Width 32, two pipeline stages, 4-bit tags
// Expected values come from a separate model of the MINMAX and SGNJ rules
// ------------------------------
`timescale 1ns/10ps

module tb_fpu_noncomp_slice import fpu_slice_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 3000;   // Tests need about 1200 cycles

  localparam logic [31:0] POS_ZERO = 32'h0000_0000;
  localparam logic [31:0] NEG_ZERO = 32'h8000_0000;
  localparam logic [31:0] ONE      = 32'h3f80_0000;
  localparam logic [31:0] QNAN     = 32'hffc0_1234;
  localparam logic [31:0] SNAN     = 32'h7f80_0042;

  typedef struct packed {
    logic [31:0] res;
    status_t     st;
    logic [3:0]  tag;
  } exp_t;

  logic             clk;
  logic             arst_n;
  logic [1:0][31:0] operands;
  operation_e       op;
  logic             op_mod;
  fp_format_e       fmt;
  logic             vec;
  logic [3:0]       tag;
  logic             in_valid;
  logic             in_ready;
  logic             flush;
  logic [31:0]      result;
  status_t          status;
  logic [3:0]       tag_out;
  logic             out_valid;
  logic             out_ready;
  logic             busy;

  exp_t       exp_q [$];
  exp_t       head;         // Oldest expected item, updated after each edge
  logic       head_valid;
  logic       in_fire;
  logic       ready_rand;
  int         ready_mode;   // 0 always ready, 1 random, 2 stalled
  logic [3:0] next_tag;
  int         sent;
  int         received;
  int         errors;
  int         cycles;

  fpu_noncomp_slice #(
    .Width         (32),
    .NumPipeRegs   (2),
    .EnableVectors (1'b1),
    .TagType       (logic [3:0])
  ) DUT (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .operands_i     (operands),
    .op_i           (op),
    .op_mod_i       (op_mod),
    .fmt_i          (fmt),
    .vectorial_op_i (vec),
    .tag_i          (tag),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .flush_i        (flush),
    .result_o       (result),
    .status_o       (status),
    .tag_o          (tag_out),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .busy_o         (busy)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  assign out_ready = (ready_mode == 1) ? ready_rand : (ready_mode == 0);

  always @(negedge clk) ready_rand = 1'($urandom);

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int elem_width(fp_format_e f);
    case (f)
      FP32:    return 32;
      FP16:    return 16;
      default: return 8;
    endcase
  endfunction

  function automatic int exp_width(fp_format_e f);
    return (f == FP32) ? 8 : 5;
  endfunction

  // One element in the low bits of a and b
  function automatic logic [31:0] minmax_sgnj(fp_format_e f, operation_e o, logic m,
                                              logic [31:0] a, logic [31:0] b,
                                              output logic nv);
    int          w;
    int          mb;
    logic [31:0] mag_mask;
    logic [31:0] exp_ones;
    logic        a_nan;
    logic        b_nan;
    logic [32:0] key_a;
    logic [32:0] key_b;
    w        = elem_width(f);
    mb       = w - 1 - exp_width(f);
    mag_mask = (32'd1 << (w - 1)) - 32'd1;
    exp_ones = ((32'd1 << exp_width(f)) - 32'd1) << mb;
    a_nan    = ((a & exp_ones) == exp_ones) && ((a & ((32'd1 << mb) - 32'd1)) != 0);
    b_nan    = ((b & exp_ones) == exp_ones) && ((b & ((32'd1 << mb) - 32'd1)) != 0);
    nv       = 1'b0;
    if (o == SGNJ) return (32'(b[w-1] ^ m) << (w - 1)) | (a & mag_mask);
    nv = (a_nan && !a[mb-1]) || (b_nan && !b[mb-1]);
    if (a_nan && b_nan) return exp_ones | (32'd1 << (mb - 1));
    if (a_nan) return b;
    if (b_nan) return a;
    // Monotonic key with negatives below positives and -0 below +0
    key_a = a[w-1] ? {1'b0, mag_mask} - {1'b0, a & mag_mask}
                   : {1'b0, mag_mask} + 33'd1 + {1'b0, a & mag_mask};
    key_b = b[w-1] ? {1'b0, mag_mask} - {1'b0, b & mag_mask}
                   : {1'b0, mag_mask} + 33'd1 + {1'b0, b & mag_mask};
    if (m) return (key_a > key_b) ? a : b;
    return (key_a < key_b) ? a : b;
  endfunction

  function automatic exp_t expected_item(fp_format_e f, operation_e o, logic m, logic v,
                                         logic [31:0] a, logic [31:0] b, logic [3:0] t);
    exp_t        item;
    int          w;
    int          n;
    logic [31:0] mask;
    logic [31:0] elem;
    logic        nv;
    w        = elem_width(f);
    n        = v ? 32 / w : 1;
    mask     = 32'((64'd1 << w) - 64'd1);
    item.res = '1;   // Unused elements read as ones
    item.st  = '0;
    item.tag = t;
    for (int k = 0; k < n; k++) begin
      elem       = minmax_sgnj(f, o, m, (a >> (k * w)) & mask, (b >> (k * w)) & mask, nv);
      item.st.nv = item.st.nv | nv;
      item.res   = (item.res & ~(mask << (k * w))) | ((elem & mask) << (k * w));
    end
    return item;
  endfunction

  // ------------------------------
  // Scoreboard and watchdog
  // ------------------------------
  always @(posedge clk) begin : scoreboard
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() != 0) void'(exp_q.pop_front());
      received = received + 1;
    end
    if (arst_n && in_valid && in_ready) begin
      exp_q.push_back(expected_item(fmt, op, op_mod, vec, operands[0], operands[1], tag));
      sent = sent + 1;
    end
    if (!arst_n || flush) exp_q.delete();   // Items in flight are dropped
    in_fire    <= arst_n && in_valid && in_ready;
    head_valid <= exp_q.size() != 0;
    if (exp_q.size() != 0) head <= exp_q[0];
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timed out after %0d cycles, the DUT stopped handshaking", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  unexpected_out: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_ready) |-> head_valid)
    else begin
      errors++;
      $display("Output at %0t with no matching input, item duplicated or spurious", $time);
    end

  result_check: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_ready && head_valid) |-> (result == head.res))
    else begin
      errors++;
      $display("Error at %0t: result %h, expected %h", $time, result, head.res);
    end

  status_check: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_ready && head_valid) |-> (status == head.st))
    else begin
      errors++;
      $display("Error at %0t: status %b, expected %b", $time, status, head.st);
    end

  tag_check: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_ready && head_valid) |-> (tag_out == head.tag))
    else begin
      errors++;
      $display("Error at %0t: tag %0d out of order, expected %0d", $time, tag_out, head.tag);
    end

  flush_idle: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> (!out_valid && !busy))
    else begin
      errors++;
      $display("Error at %0t: output still valid or busy one cycle after flush", $time);
    end

  reset_idle: assert property (@(posedge clk) !arst_n |-> (!out_valid && !busy))
    else begin
      errors++;
      $display("Error at %0t: output valid or busy during reset", $time);
    end

  // ------------------------------
  // Stimulus
  // ------------------------------
  function automatic logic [31:0] rand_elem(fp_format_e f);
    int          w;
    int          mb;
    logic [31:0] r;
    logic [31:0] sign;
    logic [31:0] exp_ones;
    logic [31:0] low_man;
    w        = elem_width(f);
    mb       = w - 1 - exp_width(f);
    sign     = 32'd1 << (w - 1);
    exp_ones = ((32'd1 << exp_width(f)) - 32'd1) << mb;
    low_man  = (32'd1 << (mb - 1)) - 32'd1;   // Mantissa below the quiet bit
    r        = $urandom & 32'((64'd1 << w) - 64'd1);
    case ($urandom % 8)
      0: r = '0;
      1: r = sign;
      2: r = (r & sign) | exp_ones | (32'd1 << (mb - 1)) | (r & low_man);   // Quiet NaN
      3: r = (r & sign) | exp_ones | (r & low_man) | 32'd1;                 // Signaling NaN
      4: r = (r & sign) | exp_ones;
      default: ;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] rand_word(fp_format_e f);
    logic [31:0] word;
    int          w;
    w    = elem_width(f);
    word = '0;
    for (int k = 0; k < 32 / w; k++) word = word | (rand_elem(f) << (k * w));
    return word;
  endfunction

  // Called at a falling edge and returns at the falling edge after acceptance
  task automatic send_op(input operation_e o, input logic m, input fp_format_e f,
                         input logic v, input logic [31:0] a, input logic [31:0] b);
    operands[0] = a;
    operands[1] = b;
    op          = o;
    op_mod      = m;
    fmt         = f;
    vec         = v;
    tag         = next_tag;
    in_valid    = 1'b1;
    do @(negedge clk); while (!in_fire);
    next_tag = next_tag + 4'd1;
  endtask

  // A negative pick means random
  task automatic random_batch(input int count, input int fmt_pick, input int vec_pick,
                              input int op_pick);
    fp_format_e f;
    operation_e o;
    logic       v;
    for (int i = 0; i < count; i++) begin
      f = (fmt_pick < 0) ? fp_format_e'($urandom % 3) : fp_format_e'(fmt_pick);
      o = (op_pick < 0) ? operation_e'($urandom % 2) : operation_e'(op_pick);
      v = (vec_pick < 0) ? 1'($urandom) : (vec_pick != 0);
      send_op(o, 1'($urandom), f, v, rand_word(f), rand_word(f));
    end
  endtask

  task automatic drain();
    in_valid = 1'b0;
    do @(negedge clk); while (head_valid || busy);
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s done, %0d errors so far", num, name, errors);
  endtask

  initial begin : stimulus
    void'($urandom(32'h3a85_8b4e));
    arst_n     = 1'b1;
    operands   = '0;
    op         = MINMAX;
    op_mod     = 1'b0;
    fmt        = FP32;
    vec        = 1'b0;
    tag        = '0;
    in_valid   = 1'b0;
    flush      = 1'b0;
    ready_mode = 0;
    next_tag   = '0;
    #1 arst_n = 1'b0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    send_op(MINMAX, 1'b0, FP32, 1'b0, POS_ZERO, NEG_ZERO);
    send_op(MINMAX, 1'b1, FP32, 1'b0, NEG_ZERO, POS_ZERO);
    send_op(MINMAX, 1'b0, FP32, 1'b0, QNAN, ONE);
    send_op(MINMAX, 1'b1, FP32, 1'b0, ONE, SNAN);
    send_op(MINMAX, 1'b0, FP32, 1'b0, QNAN, SNAN);   // Canonical NaN with NV
    send_op(MINMAX, 1'b1, FP32, 1'b0, QNAN, QNAN);
    random_batch(30, 0, 0, 0);
    drain();
    report_test(1, "scalar FP32 min/max");

    random_batch(20, 1, 0, -1);
    random_batch(20, 2, 0, -1);
    drain();
    report_test(2, "scalar FP16 and FP8");

    random_batch(20, 1, 1, 0);
    random_batch(20, 2, 1, 0);
    drain();
    report_test(3, "vectorial min/max");

    random_batch(48, -1, -1, 1);
    drain();
    report_test(4, "sign injection");

    ready_mode = 1;
    random_batch(200, -1, -1, -1);
    drain();
    ready_mode = 0;
    items_match: assert (sent == received)
      else begin
        errors++;
        $display("Items lost or duplicated, %0d sent and %0d received", sent, received);
      end
    report_test(5, "random back-pressure");

    ready_mode = 2;
    random_batch(2, -1, -1, -1);
    in_valid = 1'b0;
    flush    = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    @(negedge clk);   // Idle cycle checked by flush_idle
    random_batch(2, -1, -1, -1);
    in_valid = 1'b0;
    arst_n   = 1'b0;   // Reset with items in flight
    @(negedge clk);
    arst_n = 1'b1;
    ready_mode = 0;
    random_batch(4, -1, -1, -1);
    drain();
    report_test(6, "flush and reset");

    $display("Summary: %0d items sent, %0d outputs checked, %0d errors",
             sent, received, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* fpu_noncomp_slice.f */
fpu_slice_pkg.sv
lane_if.sv
operand_slicer.sv
noncomp_lane.sv
result_packer.sv
fpu_noncomp_slice.sv
tb_fpu_noncomp_slice.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_fpu_noncomp_slice \
  -f fpu_noncomp_slice.f \
  -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1
